// ==== Makefile ====
SRCS := build.f $(wildcard logic/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

obj_dir/Vtb_writeback: $(SRCS)
	verilator --binary --timing --assert --top-module tb_writeback -f build.f

run: obj_dir/Vtb_writeback
	./obj_dir/Vtb_writeback

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== build.f ====
+incdir+test
logic/riscv_pkg.sv
logic/wb_pkg.sv
logic/wb_control.sv
logic/wb_ctrl_queue.sv
logic/load_align.sv
logic/writeback_unit.sv
test/tb_writeback.sv

// ==== logic/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  wb_pkg::dout_sel_e dout_sel,
    input  logic [3:0]        mask,
    input  logic              mask_un,
    input  logic [31:0]       io_rdata,
    input  logic [31:0]       bios_rdata,
    input  logic [31:0]       dmem_rdata,
    output logic [31:0]       load_data
);

    riscv_pkg::mem_word_u word;
    logic [7:0]           sel_byte;
    logic [15:0]          sel_half;

    always_comb begin
        case (dout_sel)
            wb_pkg::dout_io:   word = io_rdata;
            wb_pkg::dout_bios: word = bios_rdata;
            default:           word = dmem_rdata;
        endcase
    end

    // Byte lane from a one-hot mask
    always_comb begin
        case (mask)
            4'b0010: sel_byte = word.bytes[1];
            4'b0100: sel_byte = word.bytes[2];
            4'b1000: sel_byte = word.bytes[3];
            default: sel_byte = word.bytes[0];
        endcase
    end

    assign sel_half = mask[3] ? word.halves[1] : word.halves[0];

    always_comb begin
        case (mask)
            4'b0001, 4'b0010, 4'b0100, 4'b1000:
                load_data = {{24{!mask_un && sel_byte[7]}}, sel_byte};
            4'b0011, 4'b1100:
                load_data = {{16{!mask_un && sel_half[15]}}, sel_half};
            4'b1111:
                load_data = word;
            default:
                load_data = 32'd0;
        endcase
    end

    // Decoder and queue only ever hand over these patterns
    always_comb begin
        assert (mask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                             4'b0011, 4'b1100, 4'b1111})
            else $error("load_align: illegal mask %b", mask);
    end

endmodule

// ==== logic/riscv_pkg.sv ====
package riscv_pkg;

    // Major opcodes, inst[6:2]
    localparam logic [4:0] opc_ari_rtype = 5'b01100;
    localparam logic [4:0] opc_ari_itype = 5'b00100;
    localparam logic [4:0] opc_load      = 5'b00000;
    localparam logic [4:0] opc_store     = 5'b01000;
    localparam logic [4:0] opc_branch    = 5'b11000;
    localparam logic [4:0] opc_jal       = 5'b11011;
    localparam logic [4:0] opc_jalr      = 5'b11001;
    localparam logic [4:0] opc_lui       = 5'b01101;
    localparam logic [4:0] opc_auipc     = 5'b00101;

    // ALU funct3
    localparam logic [2:0] fnc_add_sub = 3'b000;
    localparam logic [2:0] fnc_sll     = 3'b001;
    localparam logic [2:0] fnc_slt     = 3'b010;
    localparam logic [2:0] fnc_sltu    = 3'b011;
    localparam logic [2:0] fnc_xor     = 3'b100;
    localparam logic [2:0] fnc_srl_sra = 3'b101;
    localparam logic [2:0] fnc_or      = 3'b110;
    localparam logic [2:0] fnc_and     = 3'b111;

    // Load funct3
    localparam logic [2:0] fnc_lb  = 3'b000;
    localparam logic [2:0] fnc_lh  = 3'b001;
    localparam logic [2:0] fnc_lw  = 3'b010;
    localparam logic [2:0] fnc_lbu = 3'b100;
    localparam logic [2:0] fnc_lhu = 3'b101;

    // inst[30] variants
    localparam logic fnc2_add = 1'b0;
    localparam logic fnc2_sub = 1'b1;
    localparam logic fnc2_srl = 1'b0;
    localparam logic fnc2_sra = 1'b1;

    // Read word seen as byte lanes or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

// ==== logic/wb_control.sv ====
`timescale 1ns/1ps

module wb_control (
    input  logic [31:0]       inst,
    input  logic [31:0]       addr,
    output wb_pkg::wb_sel_e   wb_sel,
    output wb_pkg::dout_sel_e dout_sel,
    output logic [3:0]        mask,
    output logic              mask_un,
    output logic              regwen
);

    logic [4:0] opcode5;
    logic [2:0] funct3;
    logic       alt;

    assign opcode5 = inst[6:2];
    assign funct3  = inst[14:12];
    assign alt     = inst[30];

    always_comb begin
        wb_sel   = wb_pkg::wb_dont_care;
        dout_sel = wb_pkg::dout_dont_care;
        mask     = 4'b0000;
        mask_un  = 1'b0;
        regwen   = 1'b0;

        case (opcode5)
            riscv_pkg::opc_ari_rtype: begin
                case (funct3)
                    riscv_pkg::fnc_add_sub: begin
                        case (alt)
                            // ADD
                            riscv_pkg::fnc2_add: begin
                                wb_sel = wb_pkg::wb_alu;
                                regwen = 1'b1;
                            end
                            // SUB
                            riscv_pkg::fnc2_sub: begin
                                wb_sel = wb_pkg::wb_alu;
                                regwen = 1'b1;
                            end
                        endcase
                    end
                    riscv_pkg::fnc_srl_sra: begin
                        case (alt)
                            // SRL
                            riscv_pkg::fnc2_srl: begin
                                wb_sel = wb_pkg::wb_alu;
                                regwen = 1'b1;
                            end
                            // SRA
                            riscv_pkg::fnc2_sra: begin
                                wb_sel = wb_pkg::wb_alu;
                                regwen = 1'b1;
                            end
                        endcase
                    end
                    // AND OR XOR SLL SLT SLTU
                    riscv_pkg::fnc_and, riscv_pkg::fnc_or, riscv_pkg::fnc_xor,
                    riscv_pkg::fnc_sll, riscv_pkg::fnc_slt, riscv_pkg::fnc_sltu: begin
                        wb_sel = wb_pkg::wb_alu;
                        regwen = 1'b1;
                    end
                endcase
            end

            riscv_pkg::opc_ari_itype: begin
                case (funct3)
                    riscv_pkg::fnc_srl_sra: begin
                        // SRLI, SRAI
                        if (alt == riscv_pkg::fnc2_srl || alt == riscv_pkg::fnc2_sra) begin
                            wb_sel = wb_pkg::wb_alu;
                            regwen = 1'b1;
                        end
                    end
                    // ADDI SLLI SLTI SLTIU XORI ORI ANDI
                    default: begin
                        wb_sel = wb_pkg::wb_alu;
                        regwen = 1'b1;
                    end
                endcase
            end

            riscv_pkg::opc_load: begin
                wb_sel = wb_pkg::wb_mem;
                regwen = 1'b1;

                case (addr[31:28])
                    wb_pkg::addr_io:     dout_sel = wb_pkg::dout_io;
                    wb_pkg::addr_bios:   dout_sel = wb_pkg::dout_bios;
                    wb_pkg::addr_dmem:   dout_sel = wb_pkg::dout_dmem;
                    wb_pkg::addr_mirror: dout_sel = wb_pkg::dout_dmem;
                    default:             dout_sel = wb_pkg::dout_dont_care;
                endcase

                case (funct3)
                    riscv_pkg::fnc_lb: begin
                        mask = 4'b0001 << addr[1:0];
                    end
                    riscv_pkg::fnc_lbu: begin
                        mask    = 4'b0001 << addr[1:0];
                        mask_un = 1'b1;
                    end
                    riscv_pkg::fnc_lh: begin
                        // Odd halfword offsets get no lanes
                        case (addr[1:0])
                            2'b00:   mask = 4'b0011;
                            2'b10:   mask = 4'b1100;
                            default: mask = 4'b0000;
                        endcase
                    end
                    riscv_pkg::fnc_lhu: begin
                        case (addr[1:0])
                            2'b00:   mask = 4'b0011;
                            2'b10:   mask = 4'b1100;
                            default: mask = 4'b0000;
                        endcase
                        mask_un = 1'b1;
                    end
                    riscv_pkg::fnc_lw: begin
                        mask = 4'b1111;
                    end
                    default: begin
                        mask = 4'b0000;
                    end
                endcase
            end

            // No register write
            riscv_pkg::opc_store, riscv_pkg::opc_branch: begin
                regwen = 1'b0;
            end

            // JAL, JALR link pc plus 4
            riscv_pkg::opc_jal, riscv_pkg::opc_jalr: begin
                wb_sel = wb_pkg::wb_pc4;
                regwen = 1'b1;
            end

            // LUI, AUIPC result comes through the ALU
            riscv_pkg::opc_lui, riscv_pkg::opc_auipc: begin
                wb_sel = wb_pkg::wb_alu;
                regwen = 1'b1;
            end

            default: begin
                regwen = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/wb_ctrl_queue.sv ====
`timescale 1ns/1ps

module wb_ctrl_queue #(
    parameter int CREDITS = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  wb_pkg::wb_sel_e   wb_sel,
    input  wb_pkg::dout_sel_e dout_sel,
    input  logic [3:0]        mask,
    input  logic              mask_un,
    input  logic              regwen,
    input  logic [4:0]        rd,
    input  logic [31:0]       alu_result,
    input  logic [31:0]       pc,
    output logic              head_valid,
    output logic              head_is_load,
    output wb_pkg::wb_sel_e   head_wb_sel,
    output wb_pkg::dout_sel_e head_dout_sel,
    output logic [3:0]        head_mask,
    output logic              head_mask_un,
    output logic [4:0]        head_rd,
    output logic [31:0]       head_alu_result,
    output logic [31:0]       head_pc,
    output logic              head_regwen,
    input  logic              mem_rsp_valid,
    output logic              retire
);

    localparam int ptr_w = $clog2(CREDITS);
    localparam logic [ptr_w:0] depth = CREDITS[ptr_w:0];

    wb_pkg::wb_sel_e   wb_sel_q   [CREDITS];
    wb_pkg::dout_sel_e dout_sel_q [CREDITS];
    logic [3:0]        mask_q     [CREDITS];
    logic              mask_un_q  [CREDITS];
    logic              regwen_q   [CREDITS];
    logic [4:0]        rd_q       [CREDITS];
    logic [31:0]       alu_q      [CREDITS];
    logic [31:0]       pc_q       [CREDITS];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            wb_sel_q[wr_ptr]   <= wb_sel;
            dout_sel_q[wr_ptr] <= dout_sel;
            mask_q[wr_ptr]     <= mask;
            mask_un_q[wr_ptr]  <= mask_un;
            regwen_q[wr_ptr]   <= regwen;
            rd_q[wr_ptr]       <= rd;
            alu_q[wr_ptr]      <= alu_result;
            pc_q[wr_ptr]       <= pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (retire)
                rd_ptr <= rd_ptr + 1'b1;
            case ({in_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_wb_sel     = wb_sel_q[rd_ptr];
    assign head_dout_sel   = dout_sel_q[rd_ptr];
    assign head_mask       = mask_q[rd_ptr];
    assign head_mask_un    = mask_un_q[rd_ptr];
    assign head_regwen     = regwen_q[rd_ptr];
    assign head_rd         = rd_q[rd_ptr];
    assign head_alu_result = alu_q[rd_ptr];
    assign head_pc         = pc_q[rd_ptr];

    assign head_valid   = (count != '0);
    assign head_is_load = head_valid && (head_wb_sel == wb_pkg::wb_mem);

    // Loads wait at the head for their response, everything else leaves at once
    assign retire = head_valid && (!head_is_load || mem_rsp_valid);

    // Sender must hold a credit, so no push lands on a full queue
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) in_valid |-> (count != depth)
    );

    // Pointers must agree with the count whenever an entry leaves
    a_no_retire_when_empty: assert property (
        @(posedge clk) disable iff (!arst_n) retire |-> (rd_ptr != wr_ptr || count == depth)
    );

endmodule

// ==== logic/wb_pkg.sv ====
package wb_pkg;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc4 = 2'd2
    } wb_sel_e;

    localparam wb_sel_e wb_dont_care = wb_alu;

    typedef enum logic [1:0] {
        dout_io   = 2'd0,
        dout_bios = 2'd1,
        dout_dmem = 2'd2
    } dout_sel_e;

    localparam dout_sel_e dout_dont_care = dout_dmem;

    // Address bits 31:28
    localparam logic [3:0] addr_io     = 4'b1000;
    localparam logic [3:0] addr_bios   = 4'b0100;
    localparam logic [3:0] addr_dmem   = 4'b0001;
    localparam logic [3:0] addr_mirror = 4'b0011;

endpackage

// ==== logic/writeback_unit.sv ====
`timescale 1ns/1ps

module writeback_unit #(
    parameter int CREDITS = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  logic [31:0] in_inst,
    input  logic [31:0] in_addr,
    input  logic [31:0] in_pc,
    output logic        credit_return,
    input  logic        mem_rsp_valid,
    output logic        mem_rsp_ready,
    input  logic [31:0] io_rdata,
    input  logic [31:0] bios_rdata,
    input  logic [31:0] dmem_rdata,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata
);

    wb_pkg::wb_sel_e   dec_wb_sel;
    wb_pkg::dout_sel_e dec_dout_sel;
    logic [3:0]        dec_mask;
    logic              dec_mask_un;
    logic              dec_regwen;

    logic              head_is_load;
    wb_pkg::wb_sel_e   head_wb_sel;
    wb_pkg::dout_sel_e head_dout_sel;
    logic [3:0]        head_mask;
    logic              head_mask_un;
    logic [4:0]        head_rd;
    logic [31:0]       head_alu_result;
    logic [31:0]       head_pc;
    logic              head_regwen;
    logic              retire;
    logic [31:0]       load_data;

    wb_control u_control (
        .inst     (in_inst),
        .addr     (in_addr),
        .wb_sel   (dec_wb_sel),
        .dout_sel (dec_dout_sel),
        .mask     (dec_mask),
        .mask_un  (dec_mask_un),
        .regwen   (dec_regwen)
    );

    wb_ctrl_queue #(
        .CREDITS (CREDITS)
    ) u_queue (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_valid        (in_valid),
        .wb_sel          (dec_wb_sel),
        .dout_sel        (dec_dout_sel),
        .mask            (dec_mask),
        .mask_un         (dec_mask_un),
        .regwen          (dec_regwen),
        .rd              (in_inst[11:7]),
        .alu_result      (in_addr),
        .pc              (in_pc),
        .head_valid      (),
        .head_is_load    (head_is_load),
        .head_wb_sel     (head_wb_sel),
        .head_dout_sel   (head_dout_sel),
        .head_mask       (head_mask),
        .head_mask_un    (head_mask_un),
        .head_rd         (head_rd),
        .head_alu_result (head_alu_result),
        .head_pc         (head_pc),
        .head_regwen     (head_regwen),
        .mem_rsp_valid   (mem_rsp_valid),
        .retire          (retire)
    );

    load_align u_align (
        .dout_sel   (head_dout_sel),
        .mask       (head_mask),
        .mask_un    (head_mask_un),
        .io_rdata   (io_rdata),
        .bios_rdata (bios_rdata),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data)
    );

    always_comb begin
        case (head_wb_sel)
            wb_pkg::wb_mem: rf_wdata = load_data;
            wb_pkg::wb_pc4: rf_wdata = head_pc + 32'd4;
            default:        rf_wdata = head_alu_result;
        endcase
    end

    // x0 is never written
    assign rf_we         = retire && head_regwen && (head_rd != 5'd0);
    assign rf_waddr      = head_rd;
    assign credit_return = retire;
    assign mem_rsp_ready = head_is_load;

endmodule

// ==== test/wb_ref_model.svh ====
`ifndef WB_REF_MODEL_SVH
`define WB_REF_MODEL_SVH

// One in-flight instruction as the model sees it
typedef struct packed {
    logic        is_load;
    logic        writes;
    logic [4:0]  rd;
    logic [31:0] value;
    logic [2:0]  funct3;
    logic [31:0] addr;
    logic        entered_empty;
    int          enter_cycle;
} exp_entry_t;

function automatic exp_entry_t decode_expect(input logic [31:0] inst,
                                             input logic [31:0] addr,
                                             input logic [31:0] pc);
    exp_entry_t e;
    logic [4:0] opc;
    e = '0;
    opc = inst[6:2];
    e.rd = inst[11:7];
    e.funct3 = inst[14:12];
    e.addr = addr;
    case (opc)
        riscv_pkg::opc_ari_rtype, riscv_pkg::opc_ari_itype,
        riscv_pkg::opc_lui, riscv_pkg::opc_auipc: begin
            e.writes = 1'b1;
            e.value = addr;
        end
        riscv_pkg::opc_jal, riscv_pkg::opc_jalr: begin
            e.writes = 1'b1;
            e.value = pc + 32'd4;
        end
        riscv_pkg::opc_load: begin
            e.is_load = 1'b1;
            e.writes = 1'b1;
        end
        default: e.writes = 1'b0;
    endcase
    // x0 writes are dropped
    if (e.rd == 5'd0)
        e.writes = 1'b0;
    return e;
endfunction

// MIRROR and anything unmapped read DMEM
function automatic logic [31:0] region_word(input logic [31:0] addr, input logic [31:0] io,
                                            input logic [31:0] bios, input logic [31:0] dmem);
    case (addr[31:28])
        wb_pkg::addr_io:   return io;
        wb_pkg::addr_bios: return bios;
        default:           return dmem;
    endcase
endfunction

function automatic logic [31:0] expect_load(input logic [2:0] funct3, input logic [31:0] addr,
                                            input logic [31:0] word);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[{addr[1:0], 3'b000} +: 8];
    h = addr[1] ? word[31:16] : word[15:0];
    case (funct3)
        riscv_pkg::fnc_lb:  return {{24{b[7]}}, b};
        riscv_pkg::fnc_lbu: return {24'd0, b};
        // Odd halfword offsets give zero
        riscv_pkg::fnc_lh:  return addr[0] ? 32'd0 : {{16{h[15]}}, h};
        riscv_pkg::fnc_lhu: return addr[0] ? 32'd0 : {16'd0, h};
        riscv_pkg::fnc_lw:  return word;
        default:            return 32'd0;
    endcase
endfunction

`endif

// ==== test/tb_writeback.sv ====
`timescale 1ns/1ps

module tb_writeback;

    `include "wb_ref_model.svh"

    localparam int     credits_max = 4;
    localparam int     num_insts   = 2000;
    localparam longint watchdog_ns = longint'(num_insts) * 20 * 4;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        in_valid;
    logic [31:0] in_inst;
    logic [31:0] in_addr;
    logic [31:0] in_pc;
    logic        credit_return;
    logic        mem_rsp_valid;
    logic        mem_rsp_ready;
    logic [31:0] io_rdata;
    logic [31:0] bios_rdata;
    logic [31:0] dmem_rdata;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    exp_entry_t model_q[$];
    int sent_count = 0;
    int returned = 0;
    int cycle = 0;
    int loads_pushed = 0;
    int loads_answered = 0;

    writeback_unit #(
        .CREDITS (credits_max)
    ) dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_inst       (in_inst),
        .in_addr       (in_addr),
        .in_pc         (in_pc),
        .credit_return (credit_return),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .io_rdata      (io_rdata),
        .bios_rdata    (bios_rdata),
        .dmem_rdata    (dmem_rdata),
        .rf_we         (rf_we),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata)
    );

    always #2 clk = ~clk;

    function automatic int credits_held();
        return credits_max - sent_count + returned;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            fail_run("DUT output differs from the reference model");
        end
    endtask

    task automatic gen_instruction(output logic [31:0] inst, output logic [31:0] addr);
        logic [31:0] r;
        logic [4:0]  opc;
        inst = $urandom;
        addr = $urandom;
        r = $urandom;
        case ($urandom_range(0, 11))
            0:       opc = riscv_pkg::opc_ari_rtype;
            1:       opc = riscv_pkg::opc_ari_itype;
            2, 3, 4: opc = riscv_pkg::opc_load;
            5:       opc = riscv_pkg::opc_store;
            6:       opc = riscv_pkg::opc_branch;
            7:       opc = riscv_pkg::opc_jal;
            8:       opc = riscv_pkg::opc_jalr;
            9:       opc = riscv_pkg::opc_lui;
            10:      opc = riscv_pkg::opc_auipc;
            // Unused major opcodes
            default: opc = (r[1:0] == 2'd0) ? 5'b00011 : (r[1] ? 5'b11100 : 5'b10101);
        endcase
        inst[6:0] = {opc, 2'b11};
        if (opc == riscv_pkg::opc_load) begin
            case ($urandom_range(0, 4))
                0:       inst[14:12] = riscv_pkg::fnc_lb;
                1:       inst[14:12] = riscv_pkg::fnc_lh;
                2:       inst[14:12] = riscv_pkg::fnc_lw;
                3:       inst[14:12] = riscv_pkg::fnc_lbu;
                default: inst[14:12] = riscv_pkg::fnc_lhu;
            endcase
            case ($urandom_range(0, 3))
                0:       addr[31:28] = wb_pkg::addr_io;
                1:       addr[31:28] = wb_pkg::addr_bios;
                2:       addr[31:28] = wb_pkg::addr_dmem;
                default: addr[31:28] = wb_pkg::addr_mirror;
            endcase
        end
        if ($urandom_range(0, 7) == 0)
            inst[11:7] = 5'd0;
    endtask

    initial begin : stimulus
        logic [31:0] inst;
        logic [31:0] addr;
        logic [31:0] r;
        void'($urandom(32'h26a8_9815));
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_inst = 32'd0;
        in_addr = 32'd0;
        in_pc = 32'd0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        while (sent_count < num_insts) begin
            @(posedge clk);
            #1;
            gen_instruction(inst, addr);
            r = $urandom;
            in_inst = inst;
            in_addr = addr;
            in_pc = {r[31:2], 2'b00};
            if (credits_held() > 0 && $urandom_range(0, 3) != 0) begin
                in_valid = 1'b1;
                sent_count = sent_count + 1;
            end else begin
                in_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (model_q.size() != 0)
            @(posedge clk);
        check(32'(returned), 32'(sent_count), "credit return count");
        repeat (5) @(posedge clk);
        $display("Test passed");
        $finish;
    end

    // Memory responder, one response per load in order
    initial begin : responder
        mem_rsp_valid = 1'b0;
        io_rdata = 32'd0;
        bios_rdata = 32'd0;
        dmem_rdata = 32'd0;
        forever begin
            @(posedge clk);
            if (loads_pushed > loads_answered) begin
                repeat ($urandom_range(0, 5)) @(posedge clk);
                #1;
                io_rdata = $urandom;
                bios_rdata = $urandom;
                dmem_rdata = $urandom;
                while (bios_rdata == io_rdata)
                    bios_rdata = $urandom;
                while (dmem_rdata == io_rdata || dmem_rdata == bios_rdata)
                    dmem_rdata = $urandom;
                mem_rsp_valid = 1'b1;
                loads_answered = loads_answered + 1;
                @(negedge clk);
                while (!(mem_rsp_valid && mem_rsp_ready))
                    @(negedge clk);
                @(posedge clk);
                #1;
                mem_rsp_valid = 1'b0;
            end
        end
    end

    // Scoreboard sampled mid-cycle
    always @(negedge clk) begin : scoreboard
        exp_entry_t  head;
        exp_entry_t  e;
        logic        exp_retire;
        logic [31:0] exp_data;
        cycle = cycle + 1;
        if (credit_return) begin
            returned = returned + 1;
            if (credits_held() > credits_max)
                fail_run("more credits came back than instructions were sent");
        end
        if (model_q.size() == 0) begin
            check(32'(credit_return), 32'd0, "credit_return with no entry");
            check(32'(mem_rsp_ready), 32'd0, "mem_rsp_ready with no entry");
            check(32'(rf_we), 32'd0, "rf_we with no entry");
        end else begin
            head = model_q[0];
            exp_retire = !head.is_load || mem_rsp_valid;
            check(32'(mem_rsp_ready), 32'(head.is_load), "mem_rsp_ready");
            check(32'(credit_return), 32'(exp_retire), "credit_return");
            if (exp_retire) begin
                check(32'(rf_we), 32'(head.writes), "rf_we");
                if (head.writes) begin
                    check(32'(rf_waddr), 32'(head.rd), "rf_waddr");
                    if (head.is_load)
                        exp_data = expect_load(head.funct3, head.addr,
                            region_word(head.addr, io_rdata, bios_rdata, dmem_rdata));
                    else
                        exp_data = head.value;
                    check(rf_wdata, exp_data, "rf_wdata");
                end
                if (!head.is_load && head.entered_empty)
                    check(32'(cycle - head.enter_cycle), 32'd1, "non-load retire latency");
                void'(model_q.pop_front());
            end else begin
                check(32'(rf_we), 32'd0, "rf_we while load waits");
            end
        end
        if (in_valid) begin
            e = decode_expect(in_inst, in_addr, in_pc);
            e.enter_cycle = cycle;
            e.entered_empty = (model_q.size() == 0);
            model_q.push_back(e);
            if (e.is_load)
                loads_pushed = loads_pushed + 1;
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        fail_run("watchdog expired before all instructions retired");
    end

endmodule
